//--- common/wb_sram_defs.svh
/*
 * Geometry and timing of the banked Wishbone SRAM.
 * Include in any file that sizes memory, banks or the read path.
 */
`ifndef WB_SRAM_DEFS_SVH
`define WB_SRAM_DEFS_SVH

`define WB_SRAM_WORDS           64  // Total 32-bit words
`define WB_SRAM_DATA_WIDTH      32
`define WB_SRAM_BANKS           4   // Power of two, interleaved on low bits
`define WB_SRAM_READ_LATENCY    2   // Cycles from RAM enable to data out

// Read FIFO, room for a full pipe of reads plus slack
`define WB_SRAM_FIFO_DEPTH      (`WB_SRAM_READ_LATENCY + 2)
`define WB_SRAM_FIFO_THRESHOLD  2   // Free entries below this are almost full

`endif

//--- common/sram_types_pkg.sv
/*
 * Types of the memory side: data words, word addresses and their
 * split into bank and row, and the tag that follows each read.
 */
`include "wb_sram_defs.svh"

package sram_types_pkg;

  localparam int ADDR_WIDTH = $clog2(`WB_SRAM_WORDS);
  localparam int BANK_WIDTH = $clog2(`WB_SRAM_BANKS);
  localparam int ROW_WIDTH  = ADDR_WIDTH - BANK_WIDTH;

  typedef logic [`WB_SRAM_DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0]          addr_t;

  // Bank from the low address bits, row from the rest
  typedef logic [BANK_WIDTH-1:0] bank_t;
  typedef logic [ROW_WIDTH-1:0]  row_t;

  typedef struct packed {
    logic  valid;  // A read was issued
    bank_t bank;   // Bank whose data returns
  } read_tag_t;

endpackage

//--- common/wb_bus_pkg.sv
/*
 * Types of the Wishbone classic side of the slave.
 * The access kind doubles as the front end's state.
 */
`include "wb_sram_defs.svh"

package wb_bus_pkg;

  typedef logic [$clog2(`WB_SRAM_WORDS)-1:0] wb_adr_t;

  typedef enum logic [1:0] {
    WB_IDLE,
    WB_WRITE,   // Write issued, ack next
    WB_READ     // Read issued, waiting on FIFO
  } wb_access_t;

endpackage

//--- rtl/pipe_delay.sv
/*
 * Fixed-length delay line for any packed payload type.
 * All stages return to zero on reset and on clear.
 */
`include "wb_sram_defs.svh"

module pipe_delay #(
  parameter int  DELAY = `WB_SRAM_READ_LATENCY,
  parameter type T     = logic
)(
  input  var logic i_read_clk,
  input  var logic i_read_rst_n,
  input  var logic i_clear,
  input  var T     i_d,
  output T         o_d
);

  if (DELAY == 0) begin : g_bypass
    assign o_d = i_d;
  end else begin : g_shift
    T stage_q [DELAY];

    always_ff @(posedge i_read_clk or negedge i_read_rst_n) begin
      if (!i_read_rst_n) begin
        for (int i = 0; i < DELAY; i++) begin
          stage_q[i] <= '0;
        end
      end else if (i_clear) begin
        for (int i = 0; i < DELAY; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= i_d;
        for (int i = 1; i < DELAY; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign o_d = stage_q[DELAY-1];
  end

endmodule

//--- rtl/sync_fifo.sv
/*
 * Single-clock FIFO for returned read words. Output shows the head
 * word while not empty. Almost full flags fewer than THRESHOLD free.
 */
`include "wb_sram_defs.svh"

module sync_fifo #(
  parameter int DEPTH     = `WB_SRAM_FIFO_DEPTH,
  parameter int THRESHOLD = `WB_SRAM_FIFO_THRESHOLD
)(
  input  var logic                  i_read_clk,
  input  var logic                  i_read_rst_n,
  input  var logic                  i_clear,
  input  var logic                  i_push,
  input  var sram_types_pkg::data_t i_data,
  input  var logic                  i_pop,
  output logic                      o_empty,
  output logic                      o_almost_full,
  output sram_types_pkg::data_t     o_data
);
  import sram_types_pkg::*;

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  data_t                  mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr_q;
  logic [PTR_WIDTH-1:0]   rd_ptr_q;
  logic [COUNT_WIDTH-1:0] count_q;
  logic                   push_ok;
  logic                   pop_ok;

  always_comb begin
    push_ok       = i_push && (count_q != COUNT_WIDTH'(DEPTH));
    pop_ok        = i_pop && (count_q != '0);
    o_empty       = count_q == '0;
    o_almost_full = (COUNT_WIDTH'(DEPTH) - count_q) < COUNT_WIDTH'(THRESHOLD);
    o_data        = mem[rd_ptr_q];
  end

  always_ff @(posedge i_read_clk) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= i_data;
    end
  end

  // ********************************************************************
  // Pointers and count
  // ********************************************************************
  always_ff @(posedge i_read_clk or negedge i_read_rst_n) begin
    if (!i_read_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (i_clear) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + COUNT_WIDTH'(push_ok) - COUNT_WIDTH'(pop_ok);
    end
  end

endmodule

//--- sram/sram_1rw_model.sv
/*
 * Behavioral single-port RAM for one bank. An enabled write stores
 * the word; an enabled read registers the row and delays it so that
 * data appears the full read latency after the enable.
 */
`include "wb_sram_defs.svh"

module sram_1rw_model #(
  parameter int ROWS = `WB_SRAM_WORDS / `WB_SRAM_BANKS
)(
  input  var logic                  i_read_clk,
  input  var logic                  i_enable,
  input  var logic                  i_write,
  input  var sram_types_pkg::row_t  i_row,
  input  var sram_types_pkg::data_t i_write_data,
  output sram_types_pkg::data_t     o_read_data
);
  import sram_types_pkg::*;

  data_t mem [ROWS];
  data_t read_q;

  always_ff @(posedge i_read_clk) begin
    if (i_enable) begin
      if (i_write) begin
        mem[i_row] <= i_write_data;
      end else begin
        read_q <= mem[i_row];  // First output stage
      end
    end
  end

  // Remaining stages of the output pipe, no reset needed on data
  pipe_delay #(
    .DELAY (`WB_SRAM_READ_LATENCY - 1),
    .T     (data_t                    )
  ) u_out_delay (
    .i_read_clk   (i_read_clk  ),
    .i_read_rst_n (1'b1        ),
    .i_clear      (1'b0        ),
    .i_d          (read_q      ),
    .o_d          (o_read_data )
  );

endmodule

//--- sram/sram_banked.sv
/*
 * Banked SRAM block. One single-port RAM per bank, driven by the
 * per-bank enables from steering. Each read tag travels through a
 * delay line matching the RAM latency; when it emerges valid, the
 * named bank's word is pushed to the read FIFO.
 */
`include "wb_sram_defs.svh"

module sram_banked (
  input  var logic                      i_read_clk,
  input  var logic                      i_read_rst_n,
  input  var logic                      i_clear,
  input  var logic [`WB_SRAM_BANKS-1:0] i_bank_enable,
  input  var logic                      i_write,
  input  var sram_types_pkg::row_t      i_row,
  input  var sram_types_pkg::data_t     i_data,
  input  var sram_types_pkg::read_tag_t i_read_tag,
  output logic                          o_push,
  output sram_types_pkg::data_t         o_push_data
);
  import sram_types_pkg::*;

  localparam int ROWS = `WB_SRAM_WORDS / `WB_SRAM_BANKS;

  data_t     bank_data [`WB_SRAM_BANKS];
  read_tag_t tag_q;

  // ********************************************************************
  // Bank array
  // ********************************************************************
  for (genvar b = 0; b < `WB_SRAM_BANKS; b++) begin : g_bank
    sram_1rw_model #(
      .ROWS (ROWS)
    ) u_ram (
      .i_read_clk   (i_read_clk       ),
      .i_enable     (i_bank_enable[b] ),
      .i_write      (i_write          ),
      .i_row        (i_row            ),
      .i_write_data (i_data           ),
      .o_read_data  (bank_data[b]     )
    );
  end

  // ********************************************************************
  // Read tag tracking and bank select
  // ********************************************************************
  pipe_delay #(
    .DELAY (`WB_SRAM_READ_LATENCY),
    .T     (read_tag_t           )
  ) u_tag_delay (
    .i_read_clk   (i_read_clk   ),
    .i_read_rst_n (i_read_rst_n ),
    .i_clear      (i_clear      ),
    .i_d          (i_read_tag   ),
    .o_d          (tag_q        )
  );

  always_comb begin
    o_push      = tag_q.valid;
    o_push_data = bank_data[tag_q.bank];  // Tag bank lines up with the data
  end

endmodule

//--- rtl/sram_bank_steer.sv
/*
 * Request steering. Splits the word address into bank and row,
 * enables the selected bank and builds the read tag. Reads stall
 * while the read FIFO could not absorb every read in flight.
 */
`include "wb_sram_defs.svh"

module sram_bank_steer (
  input  var logic                       i_read_clk,
  input  var logic                       i_read_rst_n,
  input  var logic                       i_clear,
  input  var logic                       i_req_valid,
  input  var logic                       i_req_write,
  input  var sram_types_pkg::addr_t      i_req_addr,
  input  var sram_types_pkg::data_t      i_req_data,
  output logic                           o_req_ready,
  output logic [`WB_SRAM_BANKS-1:0]      o_bank_enable,
  output logic                           o_write,
  output sram_types_pkg::row_t           o_row,
  output sram_types_pkg::data_t          o_data,
  output sram_types_pkg::read_tag_t      o_read_tag,
  input  var logic                       i_fifo_almost_full
);
  import sram_types_pkg::*;

  localparam int LAT       = `WB_SRAM_READ_LATENCY;
  localparam int CNT_WIDTH = $clog2(LAT + 2);

  bank_t                bank;
  logic                 read_ok;
  logic                 ready;
  logic                 read_issue;
  logic [LAT-1:0]       issue_sr;      // One bit per read pipe stage
  logic [CNT_WIDTH-1:0] inflight_q;

  always_comb begin
    bank       = bank_t'(i_req_addr);
    read_ok    = !i_fifo_almost_full &&
                 (inflight_q < CNT_WIDTH'(`WB_SRAM_FIFO_THRESHOLD));
    ready      = i_req_write || read_ok;  // Writes never wait
    read_issue = i_req_valid && !i_req_write && read_ok;

    o_bank_enable = '0;
    if (i_req_valid && ready) begin
      o_bank_enable[bank] = 1'b1;
    end

    o_req_ready      = ready;
    o_write          = i_req_write;
    o_row            = row_t'(i_req_addr >> BANK_WIDTH);
    o_data           = i_req_data;
    o_read_tag.valid = read_issue;
    o_read_tag.bank  = bank;
  end

  always_ff @(posedge i_read_clk or negedge i_read_rst_n) begin
    if (!i_read_rst_n) begin
      issue_sr   <= '0;
      inflight_q <= '0;
    end else if (i_clear) begin
      issue_sr   <= '0;
      inflight_q <= '0;
    end else begin
      issue_sr   <= LAT'({issue_sr, read_issue});
      inflight_q <= inflight_q + CNT_WIDTH'(read_issue) - CNT_WIDTH'(issue_sr[LAT-1]);
    end
  end

endmodule

//--- rtl/wb_sram_slave.sv
/*
 * Wishbone classic slave front end. Turns each bus cycle into one
 * request, acks writes one cycle later and reads once their word
 * reaches the read FIFO. Words of abandoned reads are dropped.
 */
`include "wb_sram_defs.svh"

module wb_sram_slave (
  input  var logic                    i_read_clk,
  input  var logic                    i_read_rst_n,
  input  var logic                    i_clear,
  input  var logic                    i_wb_cyc,
  input  var logic                    i_wb_stb,
  input  var logic                    i_wb_we,
  input  var wb_bus_pkg::wb_adr_t     i_wb_adr,
  input  var sram_types_pkg::data_t   i_wb_dat,
  output logic                        o_wb_ack,
  output sram_types_pkg::data_t       o_wb_dat,
  output logic                        o_req_valid,
  output logic                        o_req_write,
  output sram_types_pkg::addr_t       o_req_addr,
  output sram_types_pkg::data_t       o_req_data,
  input  var logic                    i_req_ready,
  input  var logic                    i_rd_empty,
  input  var sram_types_pkg::data_t   i_rd_data,
  output logic                        o_rd_pop
);
  import wb_bus_pkg::*;

  localparam int DROP_WIDTH = $clog2(`WB_SRAM_FIFO_DEPTH + 1);

  wb_access_t            state_q;
  logic [DROP_WIDTH-1:0] drop_q;    // Reads still due from abandoned cycles
  logic                  bus_req;
  logic                  issue;
  logic                  discard;
  logic                  take;
  logic                  abandon;

  always_comb begin
    bus_req = i_wb_cyc && i_wb_stb;
    issue   = (state_q == WB_IDLE) && bus_req && !i_clear;
    discard = !i_rd_empty && (drop_q != '0);  // Stale words come out first
    take    = !i_rd_empty && (drop_q == '0) && (state_q == WB_READ);
    abandon = (state_q == WB_READ) && !bus_req && !take;
  end

  assign o_req_valid = issue;
  assign o_req_write = i_wb_we;
  assign o_req_addr  = i_wb_adr;
  assign o_req_data  = i_wb_dat;

  assign o_rd_pop = discard || take;
  assign o_wb_ack = bus_req && !i_clear && ((state_q == WB_WRITE) || take);
  assign o_wb_dat = i_rd_data;

  // ********************************************************************
  // Access state and discard count
  // ********************************************************************
  always_ff @(posedge i_read_clk or negedge i_read_rst_n) begin
    if (!i_read_rst_n) begin
      state_q <= WB_IDLE;
      drop_q  <= '0;
    end else if (i_clear) begin
      state_q <= WB_IDLE;   // Reads in flight are flushed too
      drop_q  <= '0;
    end else begin
      case (state_q)
        WB_IDLE: begin
          if (issue && i_req_ready) begin
            state_q <= i_wb_we ? WB_WRITE : WB_READ;
          end
        end
        WB_READ: begin
          if (take || !bus_req) begin
            state_q <= WB_IDLE;
          end
        end
        default: state_q <= WB_IDLE;  // Write acks for one cycle only
      endcase

      case ({abandon, discard})
        2'b10:   drop_q <= drop_q + DROP_WIDTH'(1);
        2'b01:   drop_q <= drop_q - DROP_WIDTH'(1);
        default: drop_q <= drop_q;
      endcase
    end
  end

endmodule

//--- rtl/wb_sram_top.sv
/*
 * Wishbone classic SRAM slave. Front end, bank steering, banked
 * SRAM and read FIFO in one clock domain. i_clear flushes reads
 * in flight but keeps memory contents.
 */
`include "wb_sram_defs.svh"

module wb_sram_top (
  input  var logic                  i_read_clk,
  input  var logic                  i_read_rst_n,
  input  var logic                  i_clear,
  input  var logic                  i_wb_cyc,
  input  var logic                  i_wb_stb,
  input  var logic                  i_wb_we,
  input  var wb_bus_pkg::wb_adr_t   i_wb_adr,
  input  var sram_types_pkg::data_t i_wb_dat,
  output logic                      o_wb_ack,
  output sram_types_pkg::data_t     o_wb_dat
);
  import sram_types_pkg::*;

  logic                      req_valid;
  logic                      req_write;
  addr_t                     req_addr;
  data_t                     req_data;
  logic                      req_ready;
  logic [`WB_SRAM_BANKS-1:0] bank_enable;
  logic                      bank_write;
  row_t                      bank_row;
  data_t                     bank_data;
  read_tag_t                 read_tag;
  logic                      push;
  data_t                     push_data;
  logic                      fifo_empty;
  logic                      fifo_almost_full;
  logic                      fifo_pop;
  data_t                     fifo_data;

  wb_sram_slave u_slave (
    .i_read_clk   (i_read_clk   ),
    .i_read_rst_n (i_read_rst_n ),
    .i_clear      (i_clear      ),
    .i_wb_cyc     (i_wb_cyc     ),
    .i_wb_stb     (i_wb_stb     ),
    .i_wb_we      (i_wb_we      ),
    .i_wb_adr     (i_wb_adr     ),
    .i_wb_dat     (i_wb_dat     ),
    .o_wb_ack     (o_wb_ack     ),
    .o_wb_dat     (o_wb_dat     ),
    .o_req_valid  (req_valid    ),
    .o_req_write  (req_write    ),
    .o_req_addr   (req_addr     ),
    .o_req_data   (req_data     ),
    .i_req_ready  (req_ready    ),
    .i_rd_empty   (fifo_empty   ),
    .i_rd_data    (fifo_data    ),
    .o_rd_pop     (fifo_pop     )
  );

  sram_bank_steer u_steer (
    .i_read_clk         (i_read_clk       ),
    .i_read_rst_n       (i_read_rst_n     ),
    .i_clear            (i_clear          ),
    .i_req_valid        (req_valid        ),
    .i_req_write        (req_write        ),
    .i_req_addr         (req_addr         ),
    .i_req_data         (req_data         ),
    .o_req_ready        (req_ready        ),
    .o_bank_enable      (bank_enable      ),
    .o_write            (bank_write       ),
    .o_row              (bank_row         ),
    .o_data             (bank_data        ),
    .o_read_tag         (read_tag         ),
    .i_fifo_almost_full (fifo_almost_full )
  );

  sram_banked u_banks (
    .i_read_clk    (i_read_clk   ),
    .i_read_rst_n  (i_read_rst_n ),
    .i_clear       (i_clear      ),
    .i_bank_enable (bank_enable  ),
    .i_write       (bank_write   ),
    .i_row         (bank_row     ),
    .i_data        (bank_data    ),
    .i_read_tag    (read_tag     ),
    .o_push        (push         ),
    .o_push_data   (push_data    )
  );

  sync_fifo #(
    .DEPTH     (`WB_SRAM_FIFO_DEPTH    ),
    .THRESHOLD (`WB_SRAM_FIFO_THRESHOLD)
  ) u_read_fifo (
    .i_read_clk    (i_read_clk       ),
    .i_read_rst_n  (i_read_rst_n     ),
    .i_clear       (i_clear          ),
    .i_push        (push             ),
    .i_data        (push_data        ),
    .i_pop         (fifo_pop         ),
    .o_empty       (fifo_empty       ),
    .o_almost_full (fifo_almost_full ),
    .o_data        (fifo_data        )
  );

endmodule

//--- bench/tb_wb_sram.sv
/*
 * Directed testbench for the banked Wishbone SRAM slave.
 * Runs classic bus cycles against the top level, predicts read data
 * from a reference memory and checks ack timing, strobe qualification
 * and the clear input. A watchdog bounds the run time.
 */
`include "wb_sram_defs.svh"

module tb_wb_sram;
  timeunit 1ns;
  timeprecision 100ps;

  import sram_types_pkg::*;
  import wb_bus_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DELAY     = 10;  // Inputs change after the rising edge
  localparam int LAT             = `WB_SRAM_READ_LATENCY;
  localparam int WORDS           = `WB_SRAM_WORDS;
  localparam int ACK_TIMEOUT     = 20;
  localparam int WATCHDOG_CYCLES = 2000;  // About twice what the tests take

  logic    clk;
  logic    rst_n;
  logic    clear;
  logic    cyc;
  logic    stb;
  logic    we;
  wb_adr_t adr;
  data_t   wdat;
  logic    ack;
  data_t   rdat;

  data_t  ref_mem [int];
  integer seed;
  int     data_errors;
  int     ack_errors;
  int     last_latency;  // Cycles from first strobe cycle to ack

  wb_sram_top dut_i (
    .i_read_clk   (clk   ),
    .i_read_rst_n (rst_n ),
    .i_clear      (clear ),
    .i_wb_cyc     (cyc   ),
    .i_wb_stb     (stb   ),
    .i_wb_we      (we    ),
    .i_wb_adr     (adr   ),
    .i_wb_dat     (wdat  ),
    .o_wb_ack     (ack   ),
    .o_wb_dat     (rdat  )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock periods", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  // ******************************************************************
  // Checks and bus cycles
  // ******************************************************************
  task automatic compare_word(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
      data_errors++;
    end
  endtask

  task automatic compare_latency(input int got, input int exp);
    assert (got == exp) else begin
      $display("mismatch at %0t: ack latency = %0d, expected %0d", $time, got, exp);
      ack_errors++;
    end
  endtask

  task automatic expect_no_ack(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (ack === 1'b0) else begin
        $display("mismatch at %0t: o_wb_ack = %b, expected 0", $time, ack);
        ack_errors++;
      end
    end
  endtask

  task automatic run_cycle(input logic write, input wb_adr_t addr, input data_t data,
                           output data_t rd);
    int waited;
    bit got;
    waited       = 0;
    got          = 0;
    rd           = '0;
    last_latency = -1;
    @(posedge clk);
    #DRIVE_DELAY;
    cyc  = 1'b1;
    stb  = 1'b1;
    we   = write;
    adr  = addr;
    wdat = data;
    while (!got && waited <= ACK_TIMEOUT) begin
      @(negedge clk);
      if (ack) begin
        got          = 1;
        last_latency = waited;
        rd           = rdat;
      end else begin
        waited++;
      end
    end
    assert (got) else begin
      $display("No ack within %0d cycles for address %0d at %0t", ACK_TIMEOUT, addr, $time);
      ack_errors++;
    end
    @(posedge clk);
    #(DRIVE_DELAY / 2);
    assert (ack === 1'b0) else begin  // Ack gone while bus still held
      $display("mismatch at %0t: o_wb_ack = %b, expected 0", $time, ack);
      ack_errors++;
    end
    #(DRIVE_DELAY - DRIVE_DELAY / 2);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_write(input wb_adr_t addr, input data_t data);
    data_t unused;
    run_cycle(1'b1, addr, data, unused);
    ref_mem[int'(addr)] = data;
  endtask

  task automatic wb_read(input wb_adr_t addr, output data_t data);
    run_cycle(1'b0, addr, '0, data);
  endtask

  task automatic read_and_compare(input wb_adr_t addr);
    data_t got;
    wb_read(addr, got);
    compare_word($sformatf("o_wb_dat[%0d]", addr), got, ref_mem[int'(addr)]);
  endtask

  // ******************************************************************
  // Directed tests
  // ******************************************************************
  task automatic test_fill_and_readback();
    int order [WORDS];
    int j;
    int tmp;
    for (int a = 0; a < WORDS; a++) begin
      wb_write(wb_adr_t'(a), data_t'($random(seed)));
      order[a] = a;
    end
    for (int i = WORDS - 1; i > 0; i--) begin  // Shuffle the read order
      j        = int'($unsigned($random(seed)) % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < WORDS; i++) begin
      read_and_compare(wb_adr_t'(order[i]));
    end
  endtask

  task automatic test_ack_timing();
    wb_write(wb_adr_t'(5), data_t'($random(seed)));
    compare_latency(last_latency, 1);
    read_and_compare(wb_adr_t'(5));
    compare_latency(last_latency, LAT + 1);
  endtask

  task automatic test_overwrite();
    wb_write(wb_adr_t'(10), data_t'($random(seed)));
    wb_write(wb_adr_t'(10), data_t'($random(seed)));
    read_and_compare(wb_adr_t'(10));
    read_and_compare(wb_adr_t'(11));  // Next bank over
  endtask

  task automatic test_partial_strobe();
    @(posedge clk);
    #DRIVE_DELAY;
    cyc  = 1'b0;
    stb  = 1'b1;
    we   = 1'b1;
    adr  = wb_adr_t'(17);
    wdat = 32'hdead_beef;
    expect_no_ack(6);
    @(posedge clk);
    #DRIVE_DELAY;
    cyc = 1'b1;
    stb = 1'b0;
    expect_no_ack(6);
    @(posedge clk);
    #DRIVE_DELAY;
    cyc = 1'b0;
    we  = 1'b0;
    for (int a = 0; a < WORDS; a++) begin
      read_and_compare(wb_adr_t'(a));
    end
  endtask

  task automatic test_clear();
    @(posedge clk);
    #DRIVE_DELAY;
    clear = 1'b1;  // While idle
    @(posedge clk);
    #DRIVE_DELAY;
    clear = 1'b0;
    expect_no_ack(3);

    @(posedge clk);
    #DRIVE_DELAY;
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = wb_adr_t'(20);
    expect_no_ack(1);
    @(posedge clk);
    #DRIVE_DELAY;
    clear = 1'b1;  // Read is in flight
    expect_no_ack(1);
    @(posedge clk);
    #DRIVE_DELAY;
    clear = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    expect_no_ack(LAT + 3);

    for (int a = 20; a < 24; a++) begin
      read_and_compare(wb_adr_t'(a));
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    clear        = 1'b0;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    wdat         = '0;
    seed         = 32'ha4a0;
    data_errors  = 0;
    ack_errors   = 0;
    last_latency = 0;

    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    expect_no_ack(1);

    test_fill_and_readback();
    test_ack_timing();
    test_overwrite();
    test_partial_strobe();
    test_clear();

    $display("Errors: %0d data, %0d ack", data_errors, ack_errors);
    if (data_errors == 0 && ack_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+common
common/sram_types_pkg.sv
common/wb_bus_pkg.sv
rtl/pipe_delay.sv
rtl/sync_fifo.sv
sram/sram_1rw_model.sv
sram/sram_banked.sv
rtl/sram_bank_steer.sv
rtl/wb_sram_slave.sv
rtl/wb_sram_top.sv
bench/tb_wb_sram.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_wb_sram
RTL_TOP   ?= wb_sram_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
PASS_TEXT ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
